// ==== design/kcpu_pkg.sv ====
//**************************************************************************
// Shared types of the program-flow controller: opcodes, instruction
// classes, branch conditions, stack sequencer states and CC bit positions
//**************************************************************************

package kcpu_pkg;

    //**********************************************************************
    // Opcodes
    //**********************************************************************
    typedef enum logic [7:0] {
        OP_NOP        = 8'h12,
        OP_LBRA       = 8'h16,                  // Long branch with 16-bit offset
        OP_BCOND_BASE = 8'h20,                  // 20..2F are short branches
        OP_RTS        = 8'h39,
        OP_JMP        = 8'h7E,
        OP_JSR        = 8'hBD
    } kcpu_op_e;

    typedef enum logic [2:0] {
        CLS_NOP,                                // Also covers unknown opcodes
        CLS_BR8,
        CLS_LBRA,
        CLS_JMP,
        CLS_JSR,
        CLS_RTS
    } kcpu_class_e;

    // Low nibble of a short branch opcode selects one of these
    typedef enum logic [3:0] {
        COND_RA,                                // Always
        COND_RN,                                // Never
        COND_HI,
        COND_LS,
        COND_CC,
        COND_CS,
        COND_NE,
        COND_EQ,
        COND_VC,
        COND_VS,
        COND_PL,
        COND_MI,
        COND_GE,
        COND_LT,
        COND_GT,
        COND_LE
    } kcpu_cond_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PUSH_LO,
        ST_PUSH_HI,
        ST_PULL_HI,
        ST_PULL_LO
    } kcpu_stk_state_e;

    //**********************************************************************
    // Condition-code byte layout
    //**********************************************************************
    localparam int CC_C = 0;
    localparam int CC_V = 1;
    localparam int CC_Z = 2;
    localparam int CC_N = 3;

endpackage

// ==== design/kcpu_decode.sv ====
//**************************************************************************
// Decode stage with instruction latch, opcode classification and busy flag
//**************************************************************************

`timescale 1ns/1ps

module kcpu_decode (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     instr_valid,
    input  logic [7:0]               opcode,
    input  logic [15:0]              operand,
    input  logic [7:0]               cc,
    input  logic                     flow_done,
    output logic                     busy,
    output logic                     d_valid,
    output kcpu_pkg::kcpu_class_e    d_class,
    output logic [1:0]               d_len,
    output kcpu_pkg::kcpu_cond_e     d_cond,
    output logic [15:0]              d_operand,
    output logic [7:0]               d_cc
);

    logic                  accept;
    logic                  is_flow;
    kcpu_pkg::kcpu_class_e cls;
    logic [1:0]            len;

    assign accept  = instr_valid && !busy;                  // Strobes during busy are lost
    assign is_flow = (cls == kcpu_pkg::CLS_JSR) || (cls == kcpu_pkg::CLS_RTS);

    always_comb begin
        cls = kcpu_pkg::CLS_NOP;
        len = 2'd1;
        case (opcode)
            kcpu_pkg::OP_NOP: begin
                cls = kcpu_pkg::CLS_NOP;
                len = 2'd1;
            end
            kcpu_pkg::OP_LBRA: begin
                cls = kcpu_pkg::CLS_LBRA;
                len = 2'd3;
            end
            kcpu_pkg::OP_JMP: begin
                cls = kcpu_pkg::CLS_JMP;
                len = 2'd3;
            end
            kcpu_pkg::OP_JSR: begin
                cls = kcpu_pkg::CLS_JSR;
                len = 2'd3;
            end
            kcpu_pkg::OP_RTS: begin
                cls = kcpu_pkg::CLS_RTS;
                len = 2'd1;
            end
            default: begin
                if (opcode[7:4] == kcpu_pkg::OP_BCOND_BASE[7:4]) begin
                    cls = kcpu_pkg::CLS_BR8;
                    len = 2'd2;
                end
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            d_valid <= 1'b0;
            busy    <= 1'b0;
        end else begin
            d_valid <= accept;
            if (accept && is_flow) begin
                busy <= 1'b1;                                   // Held until the call or return commits
            end else if (flow_done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            d_class   <= cls;
            d_len     <= len;
            d_cond    <= kcpu_pkg::kcpu_cond_e'(opcode[3:0]);
            d_operand <= operand;
            d_cc      <= cc;
        end
    end

endmodule

// ==== design/kcpu_branch_cond.sv ====
//**************************************************************************
// Branch condition stage evaluating the sixteen conditions on latched CC
//**************************************************************************

`timescale 1ns/1ps

module kcpu_branch_cond (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     d_valid,
    input  kcpu_pkg::kcpu_class_e    d_class,
    input  logic [1:0]               d_len,
    input  kcpu_pkg::kcpu_cond_e     d_cond,
    input  logic [15:0]              d_operand,
    input  logic [7:0]               d_cc,
    output logic                     b_valid,
    output kcpu_pkg::kcpu_class_e    b_class,
    output logic [1:0]               b_len,
    output logic                     b_taken,
    output logic [15:0]              b_operand
);

    logic c, v, z, n;
    logic cond_met;
    logic taken;

    assign c = d_cc[kcpu_pkg::CC_C];
    assign v = d_cc[kcpu_pkg::CC_V];
    assign z = d_cc[kcpu_pkg::CC_Z];
    assign n = d_cc[kcpu_pkg::CC_N];

    always_comb begin
        case (d_cond)
            kcpu_pkg::COND_RA: cond_met = 1'b1;
            kcpu_pkg::COND_RN: cond_met = 1'b0;
            kcpu_pkg::COND_HI: cond_met = !(c || z);
            kcpu_pkg::COND_LS: cond_met = c || z;
            kcpu_pkg::COND_CC: cond_met = !c;
            kcpu_pkg::COND_CS: cond_met = c;
            kcpu_pkg::COND_NE: cond_met = !z;
            kcpu_pkg::COND_EQ: cond_met = z;
            kcpu_pkg::COND_VC: cond_met = !v;
            kcpu_pkg::COND_VS: cond_met = v;
            kcpu_pkg::COND_PL: cond_met = !n;
            kcpu_pkg::COND_MI: cond_met = n;
            kcpu_pkg::COND_GE: cond_met = (n == v);                 // Signed compare
            kcpu_pkg::COND_LT: cond_met = (n != v);
            kcpu_pkg::COND_GT: cond_met = !z && (n == v);
            kcpu_pkg::COND_LE: cond_met = z || (n != v);
            default:           cond_met = 1'b0;
        endcase
    end

    // Only short branches depend on the flags while every other flow change is taken
    assign taken = (d_class == kcpu_pkg::CLS_BR8) ? cond_met : (d_class != kcpu_pkg::CLS_NOP);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            b_valid <= 1'b0;
        end else begin
            b_valid <= d_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (d_valid) begin
            b_class   <= d_class;
            b_len     <= d_len;
            b_taken   <= taken;
            b_operand <= d_operand;
        end
    end

endmodule

// ==== design/kcpu_stack_seq.sv ====
//**************************************************************************
// Stack sequencer with stack pointer and push/pull FSM for call and return
//**************************************************************************

`timescale 1ns/1ps

module kcpu_stack_seq #(
    parameter logic [15:0] STACK_TOP = 16'h0200
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     b_valid,
    input  kcpu_pkg::kcpu_class_e    b_class,
    input  logic [1:0]               b_len,
    input  logic                     b_taken,
    input  logic [15:0]              b_operand,
    input  logic [15:0]              pc,
    input  logic [7:0]               stk_rdata,
    output logic                     s_valid,
    output kcpu_pkg::kcpu_class_e    s_class,
    output logic [1:0]               s_len,
    output logic                     s_taken,
    output logic [15:0]              s_target,
    output logic                     stk_we,
    output logic                     stk_rd,
    output logic [15:0]              stk_addr,
    output logic [7:0]               stk_wdata
);

    kcpu_pkg::kcpu_stk_state_e state;
    logic [15:0]               sp;
    logic                      pull_last;                   // Low byte of a pull arrives now
    logic [15:0]               ret_addr;
    logic                      take_new;

    // The instruction before a call has committed by the first push cycle
    assign ret_addr = pc + 16'd3;
    assign take_new = (state == kcpu_pkg::ST_IDLE) && b_valid && !pull_last;

    //**********************************************************************
    // Sequencer FSM and stack pointer
    //**********************************************************************
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= kcpu_pkg::ST_IDLE;
            sp        <= STACK_TOP;
            pull_last <= 1'b0;
            s_valid   <= 1'b0;
        end else begin
            s_valid   <= 1'b0;
            pull_last <= 1'b0;
            case (state)
                kcpu_pkg::ST_IDLE: begin
                    if (pull_last) begin
                        s_valid <= 1'b1;                    // Return address complete
                        sp      <= sp + 16'd2;
                    end else if (b_valid) begin
                        if (b_class == kcpu_pkg::CLS_JSR) begin
                            state <= kcpu_pkg::ST_PUSH_LO;
                        end else if (b_class == kcpu_pkg::CLS_RTS) begin
                            state <= kcpu_pkg::ST_PULL_HI;
                        end else begin
                            s_valid <= 1'b1;
                        end
                    end
                end
                kcpu_pkg::ST_PUSH_LO: state <= kcpu_pkg::ST_PUSH_HI;
                kcpu_pkg::ST_PUSH_HI: begin
                    state   <= kcpu_pkg::ST_IDLE;
                    sp      <= sp - 16'd2;
                    s_valid <= 1'b1;
                end
                kcpu_pkg::ST_PULL_HI: state <= kcpu_pkg::ST_PULL_LO;
                kcpu_pkg::ST_PULL_LO: begin
                    state     <= kcpu_pkg::ST_IDLE;
                    pull_last <= 1'b1;
                end
                default: state <= kcpu_pkg::ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take_new) begin
            s_class  <= b_class;
            s_len    <= b_len;
            s_taken  <= b_taken;
            s_target <= b_operand;
        end
        if (state == kcpu_pkg::ST_PULL_LO) begin
            s_target[15:8] <= stk_rdata;                    // Data of the read at SP
        end
        if (pull_last) begin
            s_target[7:0] <= stk_rdata;
        end
    end

    //**********************************************************************
    // Stack port
    //**********************************************************************
    always_comb begin
        stk_we    = 1'b0;
        stk_rd    = 1'b0;
        stk_addr  = sp;
        stk_wdata = ret_addr[7:0];
        case (state)
            kcpu_pkg::ST_PUSH_LO: begin
                stk_we   = 1'b1;
                stk_addr = sp - 16'd1;
            end
            kcpu_pkg::ST_PUSH_HI: begin
                stk_we    = 1'b1;
                stk_addr  = sp - 16'd2;
                stk_wdata = ret_addr[15:8];
            end
            kcpu_pkg::ST_PULL_HI: stk_rd = 1'b1;
            kcpu_pkg::ST_PULL_LO: begin
                stk_rd   = 1'b1;
                stk_addr = sp + 16'd1;
            end
            default: ;
        endcase
    end

endmodule

// ==== design/kcpu_pc_unit.sv ====
//**************************************************************************
// PC update stage computing and committing the next program counter
//**************************************************************************

`timescale 1ns/1ps

module kcpu_pc_unit #(
    parameter logic [15:0] RESET_PC = 16'h0000
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     s_valid,
    input  kcpu_pkg::kcpu_class_e    s_class,
    input  logic [1:0]               s_len,
    input  logic                     s_taken,
    input  logic [15:0]              s_target,
    output logic [15:0]              pc,
    output logic                     pc_valid,
    output logic                     taken,
    output logic                     flow_done
);

    logic [15:0] seq_pc;
    logic [15:0] rel8_pc;
    logic [15:0] rel16_pc;
    logic [15:0] next_pc;

    assign seq_pc   = pc + {14'd0, s_len};
    assign rel8_pc  = pc + 16'd2 + {{8{s_target[7]}}, s_target[7:0]};
    assign rel16_pc = pc + 16'd3 + s_target;

    always_comb begin
        case (s_class)
            kcpu_pkg::CLS_BR8:  next_pc = s_taken ? rel8_pc : seq_pc;
            kcpu_pkg::CLS_LBRA: next_pc = rel16_pc;
            kcpu_pkg::CLS_JMP,
            kcpu_pkg::CLS_JSR,
            kcpu_pkg::CLS_RTS:  next_pc = s_target;             // Absolute or pulled address
            default:            next_pc = seq_pc;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc        <= RESET_PC;
            pc_valid  <= 1'b0;
            taken     <= 1'b0;
            flow_done <= 1'b0;
        end else begin
            pc_valid  <= s_valid;
            flow_done <= s_valid && ((s_class == kcpu_pkg::CLS_JSR) ||
                                     (s_class == kcpu_pkg::CLS_RTS));
            if (s_valid) begin
                pc    <= next_pc;
                taken <= s_taken;
            end else begin
                taken <= 1'b0;                              // Only meaningful with pc_valid
            end
        end
    end

endmodule

// ==== design/kcpu_ctrl_top.sv ====
//**************************************************************************
// Program-flow controller top with the four pipeline stages
//**************************************************************************

`timescale 1ns/1ps

module kcpu_ctrl_top #(
    parameter logic [15:0] RESET_PC  = 16'h0000,
    parameter logic [15:0] STACK_TOP = 16'h0200
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        instr_valid,
    input  logic [7:0]  opcode,
    input  logic [15:0] operand,
    input  logic [7:0]  cc,
    input  logic [7:0]  stk_rdata,
    output logic        busy,
    output logic [15:0] pc,
    output logic        pc_valid,
    output logic        taken,
    output logic        stk_we,
    output logic        stk_rd,
    output logic [15:0] stk_addr,
    output logic [7:0]  stk_wdata
);

    logic                  d_valid, b_valid, s_valid;
    kcpu_pkg::kcpu_class_e d_class, b_class, s_class;
    logic [1:0]            d_len, b_len, s_len;
    kcpu_pkg::kcpu_cond_e  d_cond;
    logic [15:0]           d_operand, b_operand, s_target;
    logic [7:0]            d_cc;
    logic                  b_taken, s_taken;
    logic                  flow_done;

    kcpu_decode u_decode (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .instr_valid ( instr_valid ),
        .opcode      ( opcode      ),
        .operand     ( operand     ),
        .cc          ( cc          ),
        .flow_done   ( flow_done   ),
        .busy        ( busy        ),
        .d_valid     ( d_valid     ),
        .d_class     ( d_class     ),
        .d_len       ( d_len       ),
        .d_cond      ( d_cond      ),
        .d_operand   ( d_operand   ),
        .d_cc        ( d_cc        )
    );

    kcpu_branch_cond u_branch_cond (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .d_valid     ( d_valid     ),
        .d_class     ( d_class     ),
        .d_len       ( d_len       ),
        .d_cond      ( d_cond      ),
        .d_operand   ( d_operand   ),
        .d_cc        ( d_cc        ),
        .b_valid     ( b_valid     ),
        .b_class     ( b_class     ),
        .b_len       ( b_len       ),
        .b_taken     ( b_taken     ),
        .b_operand   ( b_operand   )
    );

    kcpu_stack_seq #(
        .STACK_TOP   ( STACK_TOP   )
    ) u_stack_seq (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .b_valid     ( b_valid     ),
        .b_class     ( b_class     ),
        .b_len       ( b_len       ),
        .b_taken     ( b_taken     ),
        .b_operand   ( b_operand   ),
        .pc          ( pc          ),
        .stk_rdata   ( stk_rdata   ),
        .s_valid     ( s_valid     ),
        .s_class     ( s_class     ),
        .s_len       ( s_len       ),
        .s_taken     ( s_taken     ),
        .s_target    ( s_target    ),
        .stk_we      ( stk_we      ),
        .stk_rd      ( stk_rd      ),
        .stk_addr    ( stk_addr    ),
        .stk_wdata   ( stk_wdata   )
    );

    kcpu_pc_unit #(
        .RESET_PC    ( RESET_PC    )
    ) u_pc_unit (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .s_valid     ( s_valid     ),
        .s_class     ( s_class     ),
        .s_len       ( s_len       ),
        .s_taken     ( s_taken     ),
        .s_target    ( s_target    ),
        .pc          ( pc          ),
        .pc_valid    ( pc_valid    ),
        .taken       ( taken       ),
        .flow_done   ( flow_done   )
    );

endmodule

// ==== bench/kcpu_ctrl_model.svh ====
//**************************************************************************
// Reference model with xorshift generator, branch conditions, next-PC
// rule, commit latency and the stack memory behind the DUT's stack port
//**************************************************************************

`ifndef KCPU_CTRL_MODEL_SVH
`define KCPU_CTRL_MODEL_SVH

logic [31:0] rng_state;                                     // Seeded at time zero
logic [7:0]  stack_mem [0:65535];
logic [15:0] model_pc;                                      // Last committed counter
logic [15:0] model_sp;

function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

// Initial stack contents so that a return without a call pulls known bytes
function automatic logic [7:0] fill_byte(input logic [15:0] addr);
    return addr[15:8] ^ {addr[6:0], addr[7]} ^ 8'hC3;
endfunction

// Conditions come in complementary pairs where the odd code negates the even one
function automatic logic cond_holds(input logic [3:0] sel, input logic [7:0] flags);
    logic c;
    logic v;
    logic z;
    logic n;
    logic base;
    c = flags[kcpu_pkg::CC_C];
    v = flags[kcpu_pkg::CC_V];
    z = flags[kcpu_pkg::CC_Z];
    n = flags[kcpu_pkg::CC_N];
    case (sel[3:1])
        3'd0:    base = 1'b1;                               // Always
        3'd1:    base = !c && !z;                           // Higher
        3'd2:    base = !c;
        3'd3:    base = !z;
        3'd4:    base = !v;
        3'd5:    base = !n;
        3'd6:    base = (n ~^ v);                           // Greater or equal
        default: base = !z && (n ~^ v);                     // Greater
    endcase
    return base ^ sel[0];
endfunction

// Gives {taken, next pc} for one committed instruction
function automatic logic [16:0] model_next(input logic [7:0] op, input logic [15:0] opnd,
                                           input logic [7:0] flags, input logic [15:0] p,
                                           input logic [15:0] pulled);
    logic [15:0] npc;
    logic        tk;
    tk  = 1'b1;
    npc = p + 16'd1;
    if (op == kcpu_pkg::OP_JMP || op == kcpu_pkg::OP_JSR) begin
        npc = opnd;
    end else if (op == kcpu_pkg::OP_RTS) begin
        npc = pulled;
    end else if (op == kcpu_pkg::OP_LBRA) begin
        npc = p + 16'd3 + opnd;
    end else if (op[7:4] == 4'h2) begin
        tk  = cond_holds(op[3:0], flags);
        npc = tk ? p + 16'd2 + {{8{opnd[7]}}, opnd[7:0]} : p + 16'd2;
    end else begin
        tk = 1'b0;                                          // NOP and unknown codes
    end
    return {tk, npc};
endfunction

function automatic int commit_latency(input logic [7:0] op);
    if (op == kcpu_pkg::OP_JSR) begin
        return 6;
    end
    if (op == kcpu_pkg::OP_RTS) begin
        return 7;
    end
    return 4;
endfunction

`endif

// ==== bench/kcpu_ctrl_tb.sv ====
//**************************************************************************
// Testbench for the program-flow controller with random program stream,
// stack memory responder, reference model checks and timeout
//**************************************************************************

`timescale 1ns/1ps

module kcpu_ctrl_tb;

    localparam logic [15:0] RESET_PC       = 16'h0400;
    localparam logic [15:0] STACK_TOP      = 16'h0300;
    localparam int          N_DIRECTED     = 20;
    localparam int          N_INSTR        = 500;
    localparam int          TIMEOUT_CYCLES = N_INSTR * 8 + 50;

    logic        clk = 1'b0;
    logic        rst;
    logic        instr_valid;
    logic [7:0]  opcode;
    logic [15:0] operand;
    logic [7:0]  cc;
    logic [7:0]  stk_rdata;
    logic        busy;
    logic [15:0] pc;
    logic        pc_valid;
    logic        taken;
    logic        stk_we;
    logic        stk_rd;
    logic [15:0] stk_addr;
    logic [7:0]  stk_wdata;

    int          cyc = 0;
    int          commits = 0;
    logic        started = 1'b0;                            // First strobe has gone out
    logic        rd_pending = 1'b0;
    logic [7:0]  rd_data = 8'h00;
    int          q_cyc[$];                                  // Expected queue, one entry per strobe
    logic [7:0]  q_op[$];
    logic [15:0] q_opnd[$];
    logic [7:0]  q_cc[$];

    `include "kcpu_ctrl_model.svh"

    kcpu_ctrl_top #(
        .RESET_PC    ( RESET_PC    ),
        .STACK_TOP   ( STACK_TOP   )
    ) u_kcpu_ctrl_top (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .instr_valid ( instr_valid ),
        .opcode      ( opcode      ),
        .operand     ( operand     ),
        .cc          ( cc          ),
        .stk_rdata   ( stk_rdata   ),
        .busy        ( busy        ),
        .pc          ( pc          ),
        .pc_valid    ( pc_valid    ),
        .taken       ( taken       ),
        .stk_we      ( stk_we      ),
        .stk_rd      ( stk_rd      ),
        .stk_addr    ( stk_addr    ),
        .stk_wdata   ( stk_wdata   )
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    //**********************************************************************
    // Failure reporting and compare tasks
    //**********************************************************************
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string msg);
        abort_run($sformatf("Mismatch at time %0d ns: %s", $time, msg));
    endtask

    task automatic check_pc(input logic [15:0] got_pc, input logic got_taken,
                            input logic [15:0] exp_pc, input logic exp_taken);
        if (got_pc !== exp_pc || got_taken !== exp_taken) begin
            report_mismatch($sformatf("pc %h taken %b, expected pc %h taken %b",
                                      got_pc, got_taken, exp_pc, exp_taken));
        end
    endtask

    task automatic check_stack(input logic we, input logic rd, input logic [15:0] addr,
                               input logic [7:0] data, input logic exp_we, input logic exp_rd,
                               input logic [15:0] exp_addr, input logic [7:0] exp_data);
        if (we !== exp_we || rd !== exp_rd) begin
            report_mismatch($sformatf("stack strobes we %b rd %b, expected we %b rd %b",
                                      we, rd, exp_we, exp_rd));
        end else if ((we || rd) && addr !== exp_addr) begin
            report_mismatch($sformatf("stack address %h, expected %h", addr, exp_addr));
        end else if (we && data !== exp_data) begin
            report_mismatch($sformatf("stack write data %h, expected %h", data, exp_data));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            report_mismatch($sformatf("%s is %b, expected %b", name, got, exp));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            report_mismatch($sformatf("%s is %0d cycles, expected %0d", what, got, exp));
        end
    endtask

    //**********************************************************************
    // Stimulus
    //**********************************************************************
    task automatic issue(input logic [7:0] op, input logic [15:0] opnd, input logic [7:0] flags);
        while (busy) begin
            @(posedge clk);
            #1;
        end
        instr_valid = 1'b1;
        opcode      = op;
        operand     = opnd;
        cc          = flags;
        started     = 1'b1;
        q_cyc.push_back(cyc);
        q_op.push_back(op);
        q_opnd.push_back(opnd);
        q_cc.push_back(flags);
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
    endtask

    task automatic issue_random(input logic [7:0] op);
        logic [31:0] r;
        r = next_rand();
        issue(op, r[15:0], r[23:16]);
    endtask

    // Decode must drop this one because a call or return is in flight
    task automatic strobe_while_busy(input logic [7:0] op, input int delay);
        repeat (delay) begin                                // Still inside the busy window
            @(posedge clk);
            #1;
        end
        instr_valid = 1'b1;
        opcode      = op;
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
    endtask

    function automatic logic [7:0] pick_opcode(input logic [31:0] r);
        logic [7:0] u;
        u = r[23:16];
        case (r[3:0])
            4'd0, 4'd1: return kcpu_pkg::OP_NOP;
            4'd2, 4'd3: begin
                if (u[7:4] == 4'h2 || u == 8'h12 || u == 8'h16 || u == 8'h39 ||
                    u == 8'h7E || u == 8'hBD) begin
                    u = 8'h01;                              // Keep it outside the known codes
                end
                return u;
            end
            4'd9:         return kcpu_pkg::OP_LBRA;
            4'd10:        return kcpu_pkg::OP_JMP;
            4'd11, 4'd12: return kcpu_pkg::OP_JSR;
            4'd13, 4'd14: return kcpu_pkg::OP_RTS;
            default:      return {4'h2, r[11:8]};           // Short branch
        endcase
    endfunction

    initial begin : stimulus
        logic [31:0] r;
        logic [7:0]  op;
        int          i;
        int          a;
        int          gap;
        rst         = 1'b1;
        instr_valid = 1'b0;
        opcode      = 8'h00;
        operand     = 16'h0000;
        cc          = 8'h00;
        stk_rdata   = 8'h00;
        rng_state   = 32'd83;
        model_pc    = RESET_PC;
        model_sp    = STACK_TOP;
        for (a = 0; a < 65536; a++) begin
            stack_mem[a] = fill_byte(a[15:0]);
        end
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (3) begin
            @(posedge clk);
            #1;
        end
        issue_random(kcpu_pkg::OP_NOP);                     // Back-to-back opening burst
        issue_random(8'h01);
        issue_random(kcpu_pkg::OP_LBRA);
        issue_random(kcpu_pkg::OP_JMP);
        for (i = 0; i < 16; i++) begin
            issue_random({4'h2, i[3:0]});
        end
        for (i = N_DIRECTED; i < N_INSTR; i++) begin
            r   = next_rand();
            gap = (r[31:29] == 3'd0) ? int'(r[28:27]) : 0;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            op = pick_opcode(r);
            issue_random(op);
            if ((op == kcpu_pkg::OP_JSR || op == kcpu_pkg::OP_RTS) && r[12]) begin
                strobe_while_busy(r[20:13], int'(r[22:21]));
            end
        end
        while (q_op.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(posedge clk);
        if (commits == N_INSTR && q_op.size() == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            abort_run($sformatf("Only %0d of %0d instructions committed", commits, N_INSTR));
        end
    end

    // Read data for the previous cycle's stk_rd or else a changing filler
    always @(posedge clk) begin
        #1;
        stk_rdata = rd_pending ? rd_data : (8'hA5 ^ cyc[7:0]);
    end

    //**********************************************************************
    // Monitor at the falling edge where all DUT outputs are settled
    //**********************************************************************
    always @(negedge clk) begin : monitor
        logic [16:0] exp;
        logic [15:0] pulled;
        logic [15:0] ret;
        logic [7:0]  tail_op;
        logic        flow_tail;
        logic        exp_we;
        logic        exp_rd;
        logic [15:0] exp_addr;
        logic [7:0]  exp_data;
        int          off;
        if (cyc >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout after %0d cycles with %0d instructions committed",
                                cyc, commits));
        end else if (!rst) begin
            flow_tail = 1'b0;
            tail_op   = 8'h00;
            off       = 0;
            if (q_op.size() > 0) begin
                tail_op   = q_op[$];
                off       = cyc - q_cyc[$];
                flow_tail = (tail_op == kcpu_pkg::OP_JSR) || (tail_op == kcpu_pkg::OP_RTS);
            end
            check_flag(busy, flow_tail && off >= 1, "busy");
            if (!started) begin
                check_pc(pc, taken, RESET_PC, 1'b0);        // Reset state before any strobe
            end
            if (pc_valid) begin
                if (q_op.size() == 0) begin
                    abort_run("pc_valid pulsed with no instruction in flight");
                end else begin
                    check_count(cyc - q_cyc[0], commit_latency(q_op[0]), "commit latency");
                    pulled = {stack_mem[model_sp], stack_mem[model_sp + 16'd1]};
                    exp    = model_next(q_op[0], q_opnd[0], q_cc[0], model_pc, pulled);
                    check_pc(pc, taken, exp[15:0], exp[16]);
                    model_pc = exp[15:0];
                    if (q_op[0] == kcpu_pkg::OP_JSR) begin
                        model_sp = model_sp - 16'd2;
                    end else if (q_op[0] == kcpu_pkg::OP_RTS) begin
                        model_sp = model_sp + 16'd2;
                    end
                    void'(q_cyc.pop_front());
                    void'(q_op.pop_front());
                    void'(q_opnd.pop_front());
                    void'(q_cc.pop_front());
                    commits++;
                end
            end else if (q_op.size() > 0 && cyc - q_cyc[0] >= commit_latency(q_op[0])) begin
                report_mismatch($sformatf("pc_valid missing for opcode %h", q_op[0]));
            end
            exp_we   = 1'b0;
            exp_rd   = 1'b0;
            exp_addr = 16'h0000;
            exp_data = 8'h00;
            ret      = model_pc + 16'd3;
            if (flow_tail && (off == 3 || off == 4)) begin
                if (tail_op == kcpu_pkg::OP_JSR) begin
                    exp_we   = 1'b1;
                    exp_addr = (off == 3) ? model_sp - 16'd1 : model_sp - 16'd2;
                    exp_data = (off == 3) ? ret[7:0] : ret[15:8];
                end else begin
                    exp_rd   = 1'b1;
                    exp_addr = (off == 3) ? model_sp : model_sp + 16'd1;
                end
            end
            check_stack(stk_we, stk_rd, stk_addr, stk_wdata, exp_we, exp_rd, exp_addr, exp_data);
            if (stk_we) begin
                stack_mem[stk_addr] = stk_wdata;
            end
            rd_pending = stk_rd;
            if (stk_rd) begin
                rd_data = stack_mem[stk_addr];
            end
        end
    end

endmodule

// ==== build.f ====
+incdir+bench
design/kcpu_pkg.sv
design/kcpu_decode.sv
design/kcpu_branch_cond.sv
design/kcpu_stack_seq.sv
design/kcpu_pc_unit.sv
design/kcpu_ctrl_top.sv
bench/kcpu_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: kcpu_ctrl

sources:
  - design/kcpu_pkg.sv
  - design/kcpu_decode.sv
  - design/kcpu_branch_cond.sv
  - design/kcpu_stack_seq.sv
  - design/kcpu_pc_unit.sv
  - design/kcpu_ctrl_top.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/kcpu_ctrl_tb.sv
